// ==== list.f ====
source/glbl_pkg.sv
source/regbus_if.sv
source/glbl_bus_front.sv
source/glbl_ctrl_regs.sv
source/glbl_intr_stat.sv
source/glbl_read_resp.sv
source/glbl_reg_top.sv
bench/glbl_reg_tb.sv

// ==== bench/glbl_stimulus.txt ====
// kind addr data be : 0 boot strap in data, 1 write, 2 read with expected data,
// 3 irq pattern, 4 irq_lines check, 5 cfg outputs check, 6 reset outputs check, f end
0 00 00000001 0
2 00 82682501 0
2 01 00000103 0
2 10 82738343 0
2 08 00000000 0
6 00 00000103 0
1 05 11223344 f
1 05 aabbccdd 5
2 05 11bb33dd 0
1 10 00000000 a
2 10 00730043 0
1 17 cafef00d c
2 17 cafe0000 0
1 02 a5c3000d f
5 00 a5c3000d 0
2 02 a5c3000d 0
1 01 00000255 3
6 00 00000255 0
2 01 00000255 0
1 03 ff0000ff f
3 00 f00f00ff 0
2 04 f00f003f 0
4 00 f000003f 0
1 04 300f000f 9
2 04 c00f0030 0
4 00 c0000030 0
f 00 00000000 0

// ==== bench/glbl_reg_tb.sv ====
`default_nettype none

module glbl_reg_tb
   import glbl_pkg::*;
();

   localparam int CLK_HALF    = 2;
   localparam int MAX_RECORDS = 64;
   // Words per stimulus line
   localparam int REC_WORDS   = 4;
   localparam int ACK_LIMIT   = 8;

   logic        mclk = 1'b0;
   logic        s_reset_n;
   logic        reg_cs;
   logic        reg_wr;
   reg_addr_t   reg_addr;
   reg_data_t   reg_wdata;
   reg_be_t     reg_be;
   reg_data_t   reg_rdata;
   logic        reg_ack;
   logic        boot_run;
   logic [2:0]  timer_intr;
   logic        i2cm_intr;
   logic        usb_intr;
   logic        pwm_intr;
   logic [31:8] gpio_intr;
   logic [6:0]  periph_rst_n;
   logic [1:0]  cpu_core_rst_n;
   logic        soft_irq;
   logic [2:0]  user_irq;
   logic [15:0] cfg_riscv_ctrl;
   intr_vec_t   irq_lines;

   // Flat record memory, kind/addr/data/be per line
   logic [31:0] stim_mem [0:MAX_RECORDS*REC_WORDS-1];
   int          n_records   = 0;
   int          check_count = 0;
   int          error_count = 0;
   int          fault_count = 0;

   glbl_reg_top #(
      .NUM_SCRATCH (8)
   ) glbl_reg_top_i (
      .mclk           (mclk),
      .s_reset_n      (s_reset_n),
      .reg_cs         (reg_cs),
      .reg_wr         (reg_wr),
      .reg_addr       (reg_addr),
      .reg_wdata      (reg_wdata),
      .reg_be         (reg_be),
      .reg_rdata      (reg_rdata),
      .reg_ack        (reg_ack),
      .boot_run       (boot_run),
      .timer_intr     (timer_intr),
      .i2cm_intr      (i2cm_intr),
      .usb_intr       (usb_intr),
      .pwm_intr       (pwm_intr),
      .gpio_intr      (gpio_intr),
      .periph_rst_n   (periph_rst_n),
      .cpu_core_rst_n (cpu_core_rst_n),
      .soft_irq       (soft_irq),
      .user_irq       (user_irq),
      .cfg_riscv_ctrl (cfg_riscv_ctrl),
      .irq_lines      (irq_lines)
   );

   always #CLK_HALF mclk = ~mclk;

   //------------------------------------------------------------
   // Helpers
   //------------------------------------------------------------
   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      check_count++;
      if (actual !== expected) begin
         error_count++;
         $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
      end
   endtask

   // Called on a falling edge, returns on a falling edge
   task automatic run_access(input string name, input logic wr, input reg_addr_t addr,
                             input reg_data_t wdata, input reg_be_t be,
                             output reg_data_t rdata);
      int cycles;
      cycles    = 0;
      reg_cs    = 1'b1;
      reg_wr    = wr;
      reg_addr  = addr;
      reg_wdata = wdata;
      reg_be    = be;
      // Ack sampled mid-cycle
      do begin
         @(negedge mclk);
         cycles++;
      end while (!reg_ack && cycles < ACK_LIMIT);
      rdata = reg_rdata;
      if (!reg_ack) begin
         fault_count++;
         $display("%s: no acknowledge within %0d cycles", name, ACK_LIMIT);
      end else begin
         check_value({name, " ack delay"}, 32'd1, cycles);
      end
      reg_cs    = 1'b0;
      reg_wr    = 1'b0;
      reg_wdata = '0;
      reg_be    = '0;
      @(negedge mclk);
      // Single-cycle pulse
      check_value({name, " ack width"}, 32'd0, {31'd0, reg_ack});
   endtask

   // Request held for one cycle
   task automatic drive_irq_pattern(input intr_vec_t pattern);
      timer_intr = pattern[2:0];
      i2cm_intr  = pattern[3];
      usb_intr   = pattern[4];
      pwm_intr   = pattern[5];
      gpio_intr  = pattern[31:8];
      @(negedge mclk);
      timer_intr = '0;
      i2cm_intr  = 1'b0;
      usb_intr   = 1'b0;
      pwm_intr   = 1'b0;
      gpio_intr  = '0;
   endtask

   //------------------------------------------------------------
   // Main sequence
   //------------------------------------------------------------
   initial begin
      reg_data_t  rdata;
      logic [3:0] kind;
      reg_addr_t  addr;
      reg_data_t  data;
      reg_be_t    be;
      string      name;
      s_reset_n  = 1'b0;
      reg_cs     = 1'b0;
      reg_wr     = 1'b0;
      reg_addr   = '0;
      reg_wdata  = '0;
      reg_be     = '0;
      boot_run   = 1'b0;
      timer_intr = '0;
      i2cm_intr  = 1'b0;
      usb_intr   = 1'b0;
      pwm_intr   = 1'b0;
      gpio_intr  = '0;
      $readmemh("bench/glbl_stimulus.txt", stim_mem);
      // Count lines up to the end marker
      while (n_records < MAX_RECORDS && !$isunknown(stim_mem[n_records*REC_WORDS]) &&
             stim_mem[n_records*REC_WORDS] != 32'hf) begin
         n_records++;
      end
      if (n_records == 0 || stim_mem[0] != 32'h0) begin
         fault_count++;
         $display("Stimulus file could not be read or does not start with a boot line");
      end else begin
         // Strap must be stable during reset
         boot_run = stim_mem[2][0];
         repeat (3) @(negedge mclk);
         s_reset_n = 1'b1;
         for (int r = 1; r < n_records; r++) begin
            kind = stim_mem[r*REC_WORDS][3:0];
            addr = stim_mem[r*REC_WORDS+1][4:0];
            data = stim_mem[r*REC_WORDS+2];
            be   = stim_mem[r*REC_WORDS+3][3:0];
            name = $sformatf("line %0d kind %0d addr %h", r, kind, addr);
            case (kind)
               4'h1: run_access(name, 1'b1, addr, data, be, rdata);
               4'h2: begin
                  run_access(name, 1'b0, addr, '0, '0, rdata);
                  check_value({name, " rdata"}, data, rdata);
               end
               4'h3: drive_irq_pattern(data);
               4'h4: check_value({name, " irq_lines"}, data, irq_lines);
               // Packed as in the configuration register
               4'h5: check_value({name, " cfg outputs"}, data,
                                 {cfg_riscv_ctrl, 12'h000, soft_irq, user_irq});
               // Packed as in the reset-control register
               4'h6: check_value({name, " reset outputs"}, data,
                                 {22'd0, cpu_core_rst_n, 1'b0, periph_rst_n});
               default: begin
                  fault_count++;
                  $display("Unknown stimulus kind %h on line %0d", kind, r);
               end
            endcase
         end
      end
      $display("Checks: %0d  mismatches: %0d  other errors: %0d",
               check_count, error_count, fault_count);
      if (error_count == 0 && fault_count == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

   //------------------------------------------------------------
   // Watchdog
   //------------------------------------------------------------
   // Budget of 20 cycles per line plus margin
   initial begin
      wait (n_records > 0);
      #((n_records * 20 + 100) * 2 * CLK_HALF);
      $display("Timeout: run did not finish within %0d cycles", n_records * 20 + 100);
      $display("Simulation FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== source/glbl_reg_top.sv ====
`default_nettype none

module glbl_reg_top
   import glbl_pkg::*;
#(
   // Scratch words, 1 to 16
   parameter int NUM_SCRATCH = 8
) (
   input  wire          mclk,
   input  wire          s_reset_n,

   // Register bus
   input  logic         reg_cs,
   input  logic         reg_wr,
   input  reg_addr_t    reg_addr,
   input  reg_data_t    reg_wdata,
   input  reg_be_t      reg_be,
   output reg_data_t    reg_rdata,
   output logic         reg_ack,

   // Boot strap
   input  logic         boot_run,

   // Hardware interrupt sources
   input  logic [2:0]   timer_intr,
   input  logic         i2cm_intr,
   input  logic         usb_intr,
   input  logic         pwm_intr,
   input  logic [31:8]  gpio_intr,

   // Control outputs
   output logic [6:0]   periph_rst_n,
   output logic [1:0]   cpu_core_rst_n,
   output logic         soft_irq,
   output logic [2:0]   user_irq,
   output logic [15:0]  cfg_riscv_ctrl,
   output intr_vec_t    irq_lines
);

   intr_vec_t hw_intr;
   intr_vec_t intr_mask;
   reg_data_t ctrl_rdata;
   reg_data_t stat_rdata;

   regbus_if bus_if ();

   // Bits 7 and 6 unused, GPIO 7..0 not routed here
   assign hw_intr = {gpio_intr, 2'b00, pwm_intr, usb_intr, i2cm_intr, timer_intr};

   //------------------------------------------------------------
   // Bus front end
   //------------------------------------------------------------
   glbl_bus_front u_bus_front (
      .mclk      (mclk),
      .s_reset_n (s_reset_n),
      .reg_cs    (reg_cs),
      .reg_wr    (reg_wr),
      .reg_addr  (reg_addr),
      .reg_wdata (reg_wdata),
      .reg_be    (reg_be),
      .reg_ack   (reg_ack),
      .bus       (bus_if.front)
   );

   //------------------------------------------------------------
   // Register banks
   //------------------------------------------------------------
   glbl_ctrl_regs #(
      .NUM_SCRATCH (NUM_SCRATCH)
   ) u_ctrl_regs (
      .mclk           (mclk),
      .s_reset_n      (s_reset_n),
      .boot_run       (boot_run),
      .bus            (bus_if.regs),
      .intr_mask      (intr_mask),
      .periph_rst_n   (periph_rst_n),
      .cpu_core_rst_n (cpu_core_rst_n),
      .soft_irq       (soft_irq),
      .user_irq       (user_irq),
      .cfg_riscv_ctrl (cfg_riscv_ctrl),
      .ctrl_rdata     (ctrl_rdata)
   );

   glbl_intr_stat u_intr_stat (
      .mclk       (mclk),
      .s_reset_n  (s_reset_n),
      .bus        (bus_if.regs),
      .hw_intr    (hw_intr),
      .intr_mask  (intr_mask),
      .irq_lines  (irq_lines),
      .stat_rdata (stat_rdata)
   );

   //------------------------------------------------------------
   // Read response
   //------------------------------------------------------------
   glbl_read_resp u_read_resp (
      .mclk       (mclk),
      .s_reset_n  (s_reset_n),
      .bus        (bus_if.rd),
      .ctrl_rdata (ctrl_rdata),
      .stat_rdata (stat_rdata),
      .reg_rdata  (reg_rdata)
   );

endmodule

`default_nettype wire

// ==== source/glbl_read_resp.sv ====
`default_nettype none

module glbl_read_resp
   import glbl_pkg::*;
(
   input  wire        mclk,
   input  wire        s_reset_n,
   regbus_if.rd       bus,
   // Bank words, zero when not addressed
   input  reg_data_t  ctrl_rdata,
   input  reg_data_t  stat_rdata,
   output reg_data_t  reg_rdata
);

   reg_data_t rd_word;

   //------------------------------------------------------------
   // Read select
   //------------------------------------------------------------
   // Chip ID is a constant, no storage
   // Unmapped addresses fall through as zero from both banks
   always_comb begin
      if (bus.addr == ADDR_CHIP_ID) begin
         rd_word = CHIP_ID_VALUE;
      end else begin
         rd_word = ctrl_rdata | stat_rdata;
      end
   end

   //------------------------------------------------------------
   // Read data register
   //------------------------------------------------------------
   // Loaded on the accept edge, valid with ack
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         reg_rdata <= '0;
      end else if (bus.accept) begin
         reg_rdata <= rd_word;
      end
   end

endmodule

`default_nettype wire

// ==== source/glbl_intr_stat.sv ====
`default_nettype none

module glbl_intr_stat
   import glbl_pkg::*;
(
   input  wire        mclk,
   input  wire        s_reset_n,
   regbus_if.regs     bus,
   // Packed hardware requests, level sampled each edge
   input  intr_vec_t  hw_intr,
   input  intr_vec_t  intr_mask,
   output intr_vec_t  irq_lines,
   output reg_data_t  stat_rdata
);

   intr_vec_t intr_stat;
   intr_vec_t clr_mask;
   logic      stat_wr;

   //------------------------------------------------------------
   // Write-one-to-clear
   //------------------------------------------------------------
   assign stat_wr = bus.accept & bus.wr & (bus.addr == ADDR_INTR_STAT);

   // Ones in enabled bytes select bits to clear
   always_comb begin
      clr_mask = '0;
      if (stat_wr) begin
         for (int b = 0; b < $bits(reg_be_t); b++) begin
            if (bus.be[b]) begin
               clr_mask[b*8 +: 8] = bus.wdata[b*8 +: 8];
            end
         end
      end
   end

   //------------------------------------------------------------
   // Status capture
   //------------------------------------------------------------
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         intr_stat <= '0;
      end else begin
         // New request wins over a clear in the same cycle
         intr_stat <= (intr_stat & ~clr_mask) | hw_intr;
      end
   end

   //------------------------------------------------------------
   // Outputs
   //------------------------------------------------------------
   // Masked lines to the CPU
   assign irq_lines  = intr_mask & intr_stat;

   // Status readable at its own address only
   assign stat_rdata = (bus.addr == ADDR_INTR_STAT) ? intr_stat : '0;

endmodule

`default_nettype wire

// ==== source/glbl_ctrl_regs.sv ====
`default_nettype none

module glbl_ctrl_regs
   import glbl_pkg::*;
#(
   parameter int NUM_SCRATCH = 8
) (
   input  wire          mclk,
   input  wire          s_reset_n,
   // Boot strap, picks the reset-control power-up value
   input  logic         boot_run,
   regbus_if.regs       bus,
   output intr_vec_t    intr_mask,
   output logic [6:0]   periph_rst_n,
   output logic [1:0]   cpu_core_rst_n,
   output logic         soft_irq,
   output logic [2:0]   user_irq,
   output logic [15:0]  cfg_riscv_ctrl,
   output reg_data_t    ctrl_rdata
);

   reg_data_t rst_ctrl;
   reg_data_t cfg_reg;
   reg_data_t mailbox;
   reg_data_t scratch [NUM_SCRATCH];
   logic      wr_en;

   // Replace only the enabled bytes of a word
   function automatic reg_data_t be_merge(reg_data_t cur, reg_data_t wdata, reg_be_t be);
      reg_data_t res;
      res = cur;
      for (int b = 0; b < $bits(reg_be_t); b++) begin
         if (be[b]) begin
            res[b*8 +: 8] = wdata[b*8 +: 8];
         end
      end
      return res;
   endfunction

   // Write strobe, address decoded per register below
   assign wr_en = bus.accept & bus.wr;

   //------------------------------------------------------------
   // Fixed registers
   //------------------------------------------------------------
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         // Strap is static while in reset
         rst_ctrl  <= boot_run ? RST_CTRL_BOOT_RUN : RST_CTRL_BOOT_HOLD;
         cfg_reg   <= '0;
         intr_mask <= '0;
         mailbox   <= '0;
      end else if (wr_en) begin
         if (bus.addr == ADDR_RST_CTRL) begin
            rst_ctrl <= be_merge(rst_ctrl, bus.wdata, bus.be);
         end
         if (bus.addr == ADDR_CFG) begin
            cfg_reg <= be_merge(cfg_reg, bus.wdata, bus.be);
         end
         if (bus.addr == ADDR_INTR_MASK) begin
            intr_mask <= be_merge(intr_mask, bus.wdata, bus.be);
         end
         // Mailbox between CPU and host
         if (bus.addr == ADDR_MAILBOX) begin
            mailbox <= be_merge(mailbox, bus.wdata, bus.be);
         end
      end
   end

   //------------------------------------------------------------
   // Scratch bank
   //------------------------------------------------------------
   for (genvar i = 0; i < NUM_SCRATCH; i++) begin : g_scratch
      // Signature in first word only
      localparam reg_data_t RST_VAL = (i == 0) ? SCRATCH0_RESET : '0;
      logic wr_hit;

      assign wr_hit = wr_en && (bus.addr == reg_addr_t'(ADDR_SCRATCH_BASE + i));

      always_ff @(posedge mclk or negedge s_reset_n) begin
         if (!s_reset_n) begin
            scratch[i] <= RST_VAL;
         end else if (wr_hit) begin
            scratch[i] <= be_merge(scratch[i], bus.wdata, bus.be);
         end
      end
   end

   //------------------------------------------------------------
   // Field outputs
   //------------------------------------------------------------
   // Active-low resets straight from the register
   assign periph_rst_n   = rst_ctrl[RST_PERIPH_MSB:RST_PERIPH_LSB];
   assign cpu_core_rst_n = rst_ctrl[RST_CPU_MSB:RST_CPU_LSB];

   // CPU side configuration
   assign soft_irq       = cfg_reg[CFG_SOFT_IRQ_BIT];
   assign user_irq       = cfg_reg[CFG_USER_IRQ_MSB:CFG_USER_IRQ_LSB];
   assign cfg_riscv_ctrl = cfg_reg[CFG_RISCV_CTRL_MSB:CFG_RISCV_CTRL_LSB];

   //------------------------------------------------------------
   // Read word
   //------------------------------------------------------------
   // Zero outside this bank, merged by OR on the read side
   always_comb begin
      ctrl_rdata = '0;
      case (bus.addr)
         ADDR_RST_CTRL:  ctrl_rdata = rst_ctrl;
         ADDR_CFG:       ctrl_rdata = cfg_reg;
         ADDR_INTR_MASK: ctrl_rdata = intr_mask;
         ADDR_MAILBOX:   ctrl_rdata = mailbox;
         default:        ctrl_rdata = '0;
      endcase
      // Scratch words above the fixed map
      for (int i = 0; i < NUM_SCRATCH; i++) begin
         if (bus.addr == reg_addr_t'(ADDR_SCRATCH_BASE + i)) begin
            ctrl_rdata = scratch[i];
         end
      end
   end

endmodule

`default_nettype wire

// ==== source/glbl_bus_front.sv ====
`default_nettype none

module glbl_bus_front
   import glbl_pkg::*;
(
   input  wire       mclk,
   input  wire       s_reset_n,
   // Register bus from the master
   input  logic      reg_cs,
   input  logic      reg_wr,
   input  reg_addr_t reg_addr,
   input  reg_data_t reg_wdata,
   input  reg_be_t   reg_be,
   output logic      reg_ack,
   // Accepted access to the register side
   regbus_if.front   bus
);

   logic accept;

   //------------------------------------------------------------
   // Access acceptance
   //------------------------------------------------------------
   // New access while no ack is pending
   // Ack low again on the cycle after, so a held cs repeats every two cycles
   assign accept = reg_cs & ~reg_ack;

   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         reg_ack <= 1'b0;
      end else begin
         // Single-cycle ack per accepted access
         reg_ack <= accept;
      end
   end

   //------------------------------------------------------------
   // Forward to register side
   //------------------------------------------------------------
   assign bus.accept = accept;
   // Master holds these stable until ack
   assign bus.wr     = reg_wr;
   assign bus.addr   = reg_addr;
   assign bus.wdata  = reg_wdata;
   assign bus.be     = reg_be;

endmodule

`default_nettype wire

// ==== source/regbus_if.sv ====
`default_nettype none

// One accepted register access, front end to register side
interface regbus_if
   import glbl_pkg::*;
();

   // High for one cycle per access
   logic      accept;
   logic      wr;
   reg_addr_t addr;
   reg_data_t wdata;
   reg_be_t   be;

   // Bus front end drives the access
   modport front (output accept, wr, addr, wdata, be);

   // Register banks see the whole access
   modport regs (input accept, wr, addr, wdata, be);

   // Read side only needs the strobe and address
   modport rd (input accept, addr);

endinterface

`default_nettype wire

// ==== source/glbl_pkg.sv ====
`default_nettype none

package glbl_pkg;

   //------------------------------------------------------------
   // Bus types
   //------------------------------------------------------------
   // Word address into the 32-entry register space
   typedef logic [4:0]  reg_addr_t;
   // One register word
   typedef logic [31:0] reg_data_t;
   // One enable per data byte
   typedef logic [3:0]  reg_be_t;
   // Interrupt request, mask and status
   typedef logic [31:0] intr_vec_t;

   //------------------------------------------------------------
   // Register address map
   //------------------------------------------------------------
   localparam reg_addr_t ADDR_CHIP_ID      = 5'd0;
   localparam reg_addr_t ADDR_RST_CTRL     = 5'd1;
   localparam reg_addr_t ADDR_CFG          = 5'd2;
   localparam reg_addr_t ADDR_INTR_MASK    = 5'd3;
   localparam reg_addr_t ADDR_INTR_STAT    = 5'd4;
   localparam reg_addr_t ADDR_MAILBOX      = 5'd5;
   // Scratch bank starts here, one word per register
   localparam reg_addr_t ADDR_SCRATCH_BASE = 5'd16;

   //------------------------------------------------------------
   // Fixed and reset values
   //------------------------------------------------------------
   // Manufacturer 16'h8268, two cores, chip 5, revision 01
   localparam reg_data_t CHIP_ID_VALUE      = 32'h8268_2501;
   // CPU core 0 out of reset after boot
   localparam reg_data_t RST_CTRL_BOOT_RUN  = 32'h0000_0103;
   // CPU held, CPU interface and QSPI released
   localparam reg_data_t RST_CTRL_BOOT_HOLD = 32'h0000_0003;
   // ASCII signature in scratch 0
   localparam reg_data_t SCRATCH0_RESET     = 32'h8273_8343;

   //------------------------------------------------------------
   // Field positions
   //------------------------------------------------------------
   // Reset control register
   localparam int RST_PERIPH_LSB     = 0;
   localparam int RST_PERIPH_MSB     = 6;
   localparam int RST_CPU_LSB        = 8;
   localparam int RST_CPU_MSB        = 9;

   // Configuration register
   localparam int CFG_USER_IRQ_LSB   = 0;
   localparam int CFG_USER_IRQ_MSB   = 2;
   localparam int CFG_SOFT_IRQ_BIT   = 3;
   localparam int CFG_RISCV_CTRL_LSB = 16;
   localparam int CFG_RISCV_CTRL_MSB = 31;

endpackage

`default_nettype wire
